// File: hdl/button_debounce.sv
`timescale 1ns/1ns

module button_debounce #(
	parameter int STABLE_CYCLES = 500000
) (
	input  logic                      clock_50,
	input  logic                      rst_n,
	input  matrix_game_pkg::buttons_t buttons_n,
	output matrix_game_pkg::buttons_t presses
);

	localparam int NUM_BUTTONS = $bits(matrix_game_pkg::buttons_t);
	localparam int CNT_W = $clog2(STABLE_CYCLES + 1);

	logic [NUM_BUTTONS-1:0] pressed_raw;
	logic [NUM_BUTTONS-1:0] level_q;
	logic [NUM_BUTTONS-1:0] pulse_q;
	logic [CNT_W-1:0]       count_q [NUM_BUTTONS];

	// Buttons are active low on the pins
	assign pressed_raw = ~NUM_BUTTONS'(buttons_n);

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			level_q <= '0;
			pulse_q <= '0;
			for (int i = 0; i < NUM_BUTTONS; i++) begin
				count_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_BUTTONS; i++) begin
				pulse_q[i] <= 1'b0;
				if (pressed_raw[i] == level_q[i]) begin
					count_q[i] <= '0;
				end else if (count_q[i] == CNT_W'(STABLE_CYCLES - 1)) begin
					// New level held long enough
					count_q[i] <= '0;
					level_q[i] <= pressed_raw[i];
					pulse_q[i] <= pressed_raw[i];
				end else begin
					count_q[i] <= count_q[i] + 1'b1;
				end
			end
		end
	end

	assign presses = matrix_game_pkg::buttons_t'(pulse_q);

endmodule

// File: hdl/frame_scanner.sv
`timescale 1ns/1ns

module frame_scanner (
	input  logic                       clock_50,
	input  logic                       rst_n,
	input  matrix_game_pkg::row_t      player,
	input  matrix_game_pkg::frame_t    obstacles,
	output logic                       req,
	output matrix_game_pkg::max_word_t word,
	input  logic                       ack
);

	localparam int NUM_CONFIG = $size(matrix_game_pkg::CONFIG_WORDS);
	localparam int MSB = matrix_game_pkg::MATRIX_SIZE - 1;

	typedef enum logic [1:0] {
		ST_SNAP,
		ST_LOAD,
		ST_REQ,
		ST_WAIT
	} scan_state_e;

	scan_state_e                state_q;
	logic                       config_done_q;
	matrix_game_pkg::col_addr_t word_idx_q;
	logic                       req_q;
	matrix_game_pkg::max_word_t word_q;
	matrix_game_pkg::frame_t    composite;
	matrix_game_pkg::frame_t    snapshot_q;
	matrix_game_pkg::row_t      column;

	// Player sits in row 0
	assign composite = obstacles | matrix_game_pkg::frame_t'(player);

	// Column k gathers bit 7-k of every row, row 0 in the MSB
	always_comb begin
		for (int j = 0; j <= MSB; j++) begin
			column[MSB - j] = snapshot_q[j][3'(MSB) - word_idx_q];
		end
	end

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			state_q <= ST_LOAD;
			config_done_q <= 1'b0;
			word_idx_q <= '0;
			req_q <= 1'b0;
		end else begin
			case (state_q)
				ST_SNAP: state_q <= ST_LOAD;
				ST_LOAD: begin
					req_q <= 1'b1;
					state_q <= ST_REQ;
				end
				ST_REQ: begin
					if (ack) begin
						req_q <= 1'b0;
						state_q <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					// Serializer must drop ack before the next word
					if (!ack) begin
						if (!config_done_q && word_idx_q == 3'(NUM_CONFIG - 1)) begin
							config_done_q <= 1'b1;
							word_idx_q <= '0;
							state_q <= ST_SNAP;
						end else if (config_done_q && word_idx_q == 3'(MSB)) begin
							word_idx_q <= '0;
							state_q <= ST_SNAP;
						end else begin
							word_idx_q <= word_idx_q + 1'b1;
							state_q <= ST_LOAD;
						end
					end
				end
				default: state_q <= ST_LOAD;
			endcase
		end
	end

	// Word and snapshot carry no control meaning
	always_ff @(posedge clock_50) begin
		if (state_q == ST_SNAP)
			snapshot_q <= composite;
		if (state_q == ST_LOAD) begin
			if (config_done_q)
				word_q <= '{pad: 4'h0,
					opcode: matrix_game_pkg::max_opcode_e'({1'b0, word_idx_q} + 4'd1),
					data: column};
			else
				word_q <= matrix_game_pkg::CONFIG_WORDS[word_idx_q];
		end
	end

	assign req = req_q;
	assign word = word_q;

	a_req_held: assert property (@(posedge clock_50) disable iff (!rst_n)
		$fell(req_q) |-> $past(ack));

endmodule

// File: hdl/game_control.sv
`timescale 1ns/1ns

module game_control (
	input  logic                         clock_50,
	input  logic                         rst_n,
	input  matrix_game_pkg::buttons_t    presses,
	input  matrix_game_pkg::row_t        player,
	input  matrix_game_pkg::frame_t      obstacles,
	output matrix_game_pkg::game_state_e state,
	output logic                         game_over
);

	matrix_game_pkg::game_state_e state_q;
	matrix_game_pkg::game_state_e state_d;
	logic                         collision;

	// Only the bottom row can hit the player
	assign collision = |(player & obstacles[0]);

	always_comb begin
		state_d = state_q;
		case (state_q)
			matrix_game_pkg::IDLE: begin
				if (presses.start)
					state_d = matrix_game_pkg::PLAY;
			end
			matrix_game_pkg::PLAY: begin
				if (collision)
					state_d = matrix_game_pkg::OVER;
			end
			matrix_game_pkg::OVER: begin
				if (presses.start)
					state_d = matrix_game_pkg::IDLE;
			end
			default: state_d = matrix_game_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clock_50) begin
		if (!rst_n)
			state_q <= matrix_game_pkg::IDLE;
		else
			state_q <= state_d;
	end

	assign state = state_q;
	assign game_over = (state_q == matrix_game_pkg::OVER);

	a_state_legal: assert property (@(posedge clock_50) disable iff (!rst_n)
		state_q inside {matrix_game_pkg::IDLE, matrix_game_pkg::PLAY, matrix_game_pkg::OVER});

endmodule

// File: hdl/matrix_game_pkg.sv
package matrix_game_pkg;

	localparam int MATRIX_SIZE = 8;

	// One LED row, bit 7 drives the leftmost LED
	typedef logic [MATRIX_SIZE-1:0] row_t;

	// Index 7 is the top row, index 0 the player row
	typedef row_t [MATRIX_SIZE-1:0] frame_t;

	typedef logic [$clog2(MATRIX_SIZE)-1:0] col_addr_t;

	typedef struct packed {
		logic start;
		logic left;
		logic right;
	} buttons_t;

	// ##############################
	// MAX7219 register map
	// ##############################
	typedef enum logic [3:0] {
		NOOP         = 4'h0,
		DIGIT0       = 4'h1,
		DIGIT1       = 4'h2,
		DIGIT2       = 4'h3,
		DIGIT3       = 4'h4,
		DIGIT4       = 4'h5,
		DIGIT5       = 4'h6,
		DIGIT6       = 4'h7,
		DIGIT7       = 4'h8,
		DECODE_MODE  = 4'h9,
		INTENSITY    = 4'hA,
		SCAN_LIMIT   = 4'hB,
		SHUTDOWN     = 4'hC,
		DISPLAY_TEST = 4'hF
	} max_opcode_e;

	// Serial word, sent MSB first
	typedef struct packed {
		logic [3:0]  pad;
		max_opcode_e opcode;
		row_t        data;
	} max_word_t;

	typedef enum logic [1:0] {
		IDLE,
		PLAY,
		OVER
	} game_state_e;

	// ##############################
	// Fixed patterns
	// ##############################
	localparam row_t PLAYER_INIT = 8'h10;

	// Rows 7 down to 0
	localparam frame_t OBSTACLE_INIT = {8'hED, 8'h0C, 8'h00, 8'hC0, 8'h00, 8'h18, 8'h00, 8'h00};

	localparam logic [3:0] INTENSITY_LEVEL = 4'hA;

	// Sent once after reset, in this order
	localparam max_word_t CONFIG_WORDS [5] = '{
		'{pad: 4'h0, opcode: SHUTDOWN,     data: 8'h01},
		'{pad: 4'h0, opcode: SCAN_LIMIT,   data: 8'h07},
		'{pad: 4'h0, opcode: DECODE_MODE,  data: 8'h00},
		'{pad: 4'h0, opcode: INTENSITY,    data: {4'h0, INTENSITY_LEVEL}},
		'{pad: 4'h0, opcode: DISPLAY_TEST, data: 8'h00}
	};

endpackage

// File: hdl/matrix_game_top.sv
`timescale 1ns/1ns

module matrix_game_top #(
	parameter int STEP_CYCLES   = 25000000,
	parameter int STABLE_CYCLES = 500000,
	parameter int SCLK_DIV      = 5
) (
	input  logic clock_50,
	input  logic rst_n,
	input  logic start_n,
	input  logic left_n,
	input  logic right_n,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk,
	output logic game_over
);

	matrix_game_pkg::buttons_t    buttons_n;
	matrix_game_pkg::buttons_t    presses;
	matrix_game_pkg::game_state_e state;
	matrix_game_pkg::row_t        player;
	matrix_game_pkg::frame_t      obstacles;
	matrix_game_pkg::max_word_t   word;
	logic                         req;
	logic                         ack;

	assign buttons_n = '{start: start_n, left: left_n, right: right_n};

	// ##############################
	// Game
	// ##############################
	button_debounce #(.STABLE_CYCLES(STABLE_CYCLES)) i_debounce (
		.clock_50(clock_50), .rst_n(rst_n), .buttons_n(buttons_n), .presses(presses)
	);

	game_control i_control (
		.clock_50(clock_50), .rst_n(rst_n), .presses(presses), .player(player),
		.obstacles(obstacles), .state(state), .game_over(game_over)
	);

	player_row i_player (
		.clock_50(clock_50), .rst_n(rst_n), .state(state), .presses(presses), .player(player)
	);

	obstacle_field #(.STEP_CYCLES(STEP_CYCLES)) i_field (
		.clock_50(clock_50), .rst_n(rst_n), .state(state), .obstacles(obstacles)
	);

	// ##############################
	// Display path
	// ##############################
	frame_scanner i_scanner (
		.clock_50(clock_50), .rst_n(rst_n), .player(player), .obstacles(obstacles),
		.req(req), .word(word), .ack(ack)
	);

	max7219_serial #(.SCLK_DIV(SCLK_DIV)) i_serial (
		.clock_50(clock_50), .rst_n(rst_n), .req(req), .word(word), .ack(ack),
		.max7219_din(max7219_din), .max7219_ncs(max7219_ncs), .max7219_clk(max7219_clk)
	);

endmodule

// File: hdl/max7219_serial.sv
`timescale 1ns/1ns

module max7219_serial #(
	parameter int SCLK_DIV = 5
) (
	input  logic                       clock_50,
	input  logic                       rst_n,
	input  logic                       req,
	input  matrix_game_pkg::max_word_t word,
	output logic                       ack,
	output logic                       max7219_din,
	output logic                       max7219_ncs,
	output logic                       max7219_clk
);

	localparam int DIV_W = $clog2(SCLK_DIV + 1);

	typedef enum logic [2:0] {
		SER_IDLE,
		SER_LOW,
		SER_HIGH,
		SER_DONE,
		SER_ACK
	} ser_state_e;

	ser_state_e        state_q;
	logic [DIV_W-1:0]  div_q;
	logic              half_tick;
	logic [3:0]        bit_cnt_q;
	logic [15:0]       shift_q;
	logic              din_q;
	logic              ncs_q;
	logic              sclk_q;
	logic              ack_q;

	assign half_tick = (div_q == DIV_W'(SCLK_DIV - 1));

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			state_q <= SER_IDLE;
			div_q <= '0;
			bit_cnt_q <= '0;
			din_q <= 1'b0;
			ncs_q <= 1'b1;
			sclk_q <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			if (state_q inside {SER_LOW, SER_HIGH, SER_DONE})
				div_q <= half_tick ? '0 : div_q + 1'b1;
			case (state_q)
				SER_IDLE: begin
					if (req) begin
						// First bit goes out together with ncs falling
						ncs_q <= 1'b0;
						din_q <= word[15];
						bit_cnt_q <= '0;
						div_q <= '0;
						state_q <= SER_LOW;
					end
				end
				SER_LOW: begin
					if (half_tick) begin
						sclk_q <= 1'b1;
						state_q <= SER_HIGH;
					end
				end
				SER_HIGH: begin
					if (half_tick) begin
						sclk_q <= 1'b0;
						if (bit_cnt_q == 4'd15) begin
							state_q <= SER_DONE;
						end else begin
							bit_cnt_q <= bit_cnt_q + 1'b1;
							din_q <= shift_q[14];
							state_q <= SER_LOW;
						end
					end
				end
				SER_DONE: begin
					// Hold ncs low one more half period
					if (half_tick) begin
						ncs_q <= 1'b1;
						ack_q <= 1'b1;
						state_q <= SER_ACK;
					end
				end
				SER_ACK: begin
					if (!req) begin
						ack_q <= 1'b0;
						state_q <= SER_IDLE;
					end
				end
				default: state_q <= SER_IDLE;
			endcase
		end
	end

	// Shift register, loaded on accept and advanced after each rising edge
	always_ff @(posedge clock_50) begin
		if (state_q == SER_IDLE && req)
			shift_q <= word;
		else if (state_q == SER_HIGH && half_tick)
			shift_q <= shift_q << 1;
	end

	assign ack = ack_q;
	assign max7219_din = din_q;
	assign max7219_ncs = ncs_q;
	assign max7219_clk = sclk_q;

	a_ack_follows_req: assert property (@(posedge clock_50) disable iff (!rst_n)
		ack_q |-> (req || $fell(req)));

	a_ncs_in_word: assert property (@(posedge clock_50) disable iff (!rst_n)
		!ncs_q |-> (req && !ack_q));

endmodule

// File: hdl/obstacle_field.sv
`timescale 1ns/1ns

module obstacle_field #(
	parameter int STEP_CYCLES = 25000000
) (
	input  logic                         clock_50,
	input  logic                         rst_n,
	input  matrix_game_pkg::game_state_e state,
	output matrix_game_pkg::frame_t      obstacles
);

	localparam int STEP_W = $clog2(STEP_CYCLES + 1);

	logic [STEP_W-1:0]       step_count_q;
	logic                    step_tick;
	matrix_game_pkg::frame_t rows_q;

	// ##############################
	// Step prescaler
	// ##############################
	assign step_tick = (step_count_q == STEP_W'(STEP_CYCLES - 1));

	// ##############################
	// Row registers
	// ##############################
	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			step_count_q <= '0;
			rows_q <= '0;
		end else begin
			case (state)
				matrix_game_pkg::IDLE: begin
					rows_q <= matrix_game_pkg::OBSTACLE_INIT;
					step_count_q <= '0;
				end
				matrix_game_pkg::PLAY: begin
					if (step_tick) begin
						step_count_q <= '0;
						// Everything falls one row, top row empties
						rows_q <= {matrix_game_pkg::row_t'(0), rows_q[7:1]};
					end else begin
						step_count_q <= step_count_q + 1'b1;
					end
				end
				// Frozen after a hit
				default: ;
			endcase
		end
	end

	assign obstacles = rows_q;

endmodule

// File: hdl/player_row.sv
`timescale 1ns/1ns

module player_row (
	input  logic                         clock_50,
	input  logic                         rst_n,
	input  matrix_game_pkg::game_state_e state,
	input  matrix_game_pkg::buttons_t    presses,
	output matrix_game_pkg::row_t        player
);

	matrix_game_pkg::row_t player_q;

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			player_q <= matrix_game_pkg::PLAYER_INIT;
		end else if (state == matrix_game_pkg::IDLE) begin
			player_q <= matrix_game_pkg::PLAYER_INIT;
		end else if (state == matrix_game_pkg::PLAY) begin
			// Both pressed together cancel out
			case ({presses.left, presses.right})
				2'b10: begin
					if (!player_q[7])
						player_q <= player_q << 1;
				end
				2'b01: begin
					if (!player_q[0])
						player_q <= player_q >> 1;
				end
				default: ;
			endcase
		end
	end

	assign player = player_q;

	a_player_onehot: assert property (@(posedge clock_50) disable iff (!rst_n)
		$onehot(player_q));

endmodule

// File: list.f
hdl/matrix_game_pkg.sv
hdl/button_debounce.sv
hdl/player_row.sv
hdl/obstacle_field.sv
hdl/game_control.sv
hdl/frame_scanner.sv
hdl/max7219_serial.sv
hdl/matrix_game_top.sv
verification/matrix_game_model.sv
verification/tb_matrix_game.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_matrix_game \
	-o sim_matrix_game && ./obj_dir/sim_matrix_game > sim.log 2>&1 || echo "build or run error"
cat sim.log 2>/dev/null
grep -q "^PASS: all tests$" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

// File: verification/matrix_game_model.sv
`timescale 1ns/1ns

module matrix_game_model (
	input  logic        clock_50,
	input  logic        restore,
	input  logic        step_left,
	input  logic        step_right,
	input  logic        max7219_din,
	input  logic        max7219_ncs,
	input  logic        max7219_clk,
	output int          word_count,
	output logic [79:0] first_words,
	output int          frame_count,
	output logic [63:0] frame,
	output logic [7:0]  player,
	output logic [7:0]  prev_player
);

	int          bit_cnt = 0;
	int          words_seen = 0;
	int          frames_seen = 0;
	logic [15:0] shift_q = '0;
	logic [79:0] log_q = '0;
	logic [63:0] frame_q = '0;
	logic [7:0]  cols [8];
	logic [7:0]  player_q = 8'h10;
	logic [7:0]  prev_q = 8'h10;

	// ##############################
	// SPI word decoder
	// ##############################
	// Bit counter restarts whenever ncs is high
	always @(posedge max7219_clk or posedge max7219_ncs) begin
		logic [15:0] w;
		logic [63:0] f;
		int          c;
		if (max7219_ncs) begin
			bit_cnt <= 0;
		end else begin
			w = {shift_q[14:0], max7219_din};
			shift_q <= w;
			if (bit_cnt == 15) begin
				bit_cnt <= 0;
				if (words_seen < 5)
					log_q[16*words_seen +: 16] <= w;
				words_seen <= words_seen + 1;
				// DIGIT0 to DIGIT7 carry columns 0 to 7
				if (w[11:8] >= 4'd1 && w[11:8] <= 4'd8) begin
					c = int'(w[11:8]) - 1;
					cols[c] = w[7:0];
					if (c == 7) begin
						// Row j bit 7-k sits in column k bit 7-j
						for (int k = 0; k < 8; k++) begin
							for (int j = 0; j < 8; j++) begin
								f[8*j + 7 - k] = cols[k][7 - j];
							end
						end
						frame_q <= f;
						frames_seen <= frames_seen + 1;
					end
				end
			end else begin
				bit_cnt <= bit_cnt + 1;
			end
		end
	end

	// ##############################
	// Reference player position
	// ##############################
	always @(posedge clock_50) begin
		if (restore) begin
			player_q <= 8'h10;
			prev_q <= 8'h10;
		end else if (step_left || step_right) begin
			prev_q <= player_q;
			// Dot stops at either edge
			if (step_left && !player_q[7])
				player_q <= player_q << 1;
			else if (step_right && !player_q[0])
				player_q <= player_q >> 1;
		end
	end

	assign word_count = words_seen;
	assign first_words = log_q;
	assign frame_count = frames_seen;
	assign frame = frame_q;
	assign player = player_q;
	assign prev_player = prev_q;

endmodule

// File: verification/tb_matrix_game.sv
`timescale 1ns/1ns

module tb_matrix_game;

	localparam int STABLE_CYCLES = 4;
	localparam int SCLK_DIV = 2;
	// Rough word and frame lengths in clock_50 cycles
	localparam int WORD_CYCLES = 34 * SCLK_DIV + 8;
	localparam int FRAME_CYCLES = 8 * WORD_CYCLES + 4;
	localparam int STEP_CYCLES = 16 * FRAME_CYCLES;
	localparam int NUM_MOVES = 6;
	localparam int MAX_PLAY_FRAMES = 9 * 16 + 8;
	localparam int TIMEOUT_CYCLES =
		2 * (FRAME_CYCLES * (12 + 3 * (NUM_MOVES + 3)) + 9 * STEP_CYCLES);
	localparam int DRIVE_DELAY = 2;

	localparam int MODE_SKIP = 0;
	localparam int MODE_IDLE = 1;
	localparam int MODE_PLAY = 2;
	localparam int PIN_START = 0;
	localparam int PIN_LEFT = 1;
	localparam int PIN_RIGHT = 2;

	localparam logic [7:0]  PLAYER_START = 8'h10;
	// Rows 7 down to 0
	localparam logic [63:0] FIELD_START = 64'hED0C_00C0_0018_0000;
	// Word 0 in the low bits
	localparam logic [79:0] CONFIG_EXPECTED =
		{16'h0F00, 16'h0A0A, 16'h0900, 16'h0B07, 16'h0C01};

	logic        clock_50;
	logic        rst_n;
	logic        start_n;
	logic        left_n;
	logic        right_n;
	logic        max7219_din;
	logic        max7219_ncs;
	logic        max7219_clk;
	logic        game_over;
	logic        model_restore;
	logic        step_left;
	logic        step_right;
	int          word_count;
	int          frame_count;
	logic [79:0] first_words;
	logic [63:0] frame;
	logic [7:0]  model_player;
	logic [7:0]  prev_player;

	int          errors = 0;
	int          test_errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          frames_checked = 0;
	int          mode;
	int          k_now;
	bit          move_pending;
	bit          over_seen;
	logic [63:0] frozen_frame;

	matrix_game_top #(
		.STEP_CYCLES(STEP_CYCLES),
		.STABLE_CYCLES(STABLE_CYCLES),
		.SCLK_DIV(SCLK_DIV)
	) i_dut (
		.clock_50(clock_50), .rst_n(rst_n), .start_n(start_n), .left_n(left_n),
		.right_n(right_n), .max7219_din(max7219_din), .max7219_ncs(max7219_ncs),
		.max7219_clk(max7219_clk), .game_over(game_over)
	);

	matrix_game_model i_model (
		.clock_50(clock_50), .restore(model_restore), .step_left(step_left),
		.step_right(step_right), .max7219_din(max7219_din), .max7219_ncs(max7219_ncs),
		.max7219_clk(max7219_clk), .word_count(word_count), .first_words(first_words),
		.frame_count(frame_count), .frame(frame), .player(model_player),
		.prev_player(prev_player)
	);

	initial begin
		clock_50 = 1'b0;
		forever #10 clock_50 = ~clock_50;
	end

	// ##############################
	// Helpers
	// ##############################
	task automatic wait_frames(input int n);
		int target;
		target = frame_count + n;
		wait (frame_count >= target);
	endtask

	task automatic press_pin(input int which);
		int hold;
		hold = STABLE_CYCLES + 2 + $urandom_range(0, 4);
		@(posedge clock_50);
		#DRIVE_DELAY;
		case (which)
			PIN_START: start_n = 1'b0;
			PIN_LEFT: left_n = 1'b0;
			default: right_n = 1'b0;
		endcase
		repeat (hold) @(posedge clock_50);
		#DRIVE_DELAY;
		start_n = 1'b1;
		left_n = 1'b1;
		right_n = 1'b1;
	endtask

	// Old and new dot both allowed until two whole frames have passed
	task automatic move_player(input bit go_left);
		move_pending = 1'b1;
		@(posedge clock_50);
		#DRIVE_DELAY;
		step_left = go_left;
		step_right = !go_left;
		@(posedge clock_50);
		#DRIVE_DELAY;
		step_left = 1'b0;
		step_right = 1'b0;
		press_pin(go_left ? PIN_LEFT : PIN_RIGHT);
		wait_frames(2);
		move_pending = 1'b0;
		repeat ($urandom_range(STABLE_CYCLES + 2, 40)) @(posedge clock_50);
	endtask

	task automatic check_frame();
		logic [63:0] base;
		logic [63:0] expected;
		logic [7:0]  shown;
		bit          matched;
		matched = 1'b0;
		if (mode == MODE_IDLE) begin
			frames_checked++;
			expected = FIELD_START | {56'h0, PLAYER_START};
			if (frame !== expected) begin
				$display("ERROR idle frame: expected %h, got %h", expected, frame);
				errors++;
			end
		end else if (mode == MODE_PLAY && over_seen) begin
			frames_checked++;
			if (frame !== frozen_frame) begin
				$display("ERROR frozen frame: expected %h, got %h", frozen_frame, frame);
				errors++;
			end
			if (game_over !== 1'b1) begin
				$display("ERROR game_over: expected 1, got %h", game_over);
				errors++;
			end
		end else if (mode == MODE_PLAY) begin
			frames_checked++;
			// Field stays put or falls one row since the last frame
			for (int step = k_now; step <= k_now + 1 && !matched; step++) begin
				base = FIELD_START >> (8 * step);
				if (frame === (base | {56'h0, model_player})) begin
					matched = 1'b1;
					shown = model_player;
					k_now = step;
				end else if (move_pending && frame === (base | {56'h0, prev_player})) begin
					matched = 1'b1;
					shown = prev_player;
					k_now = step;
				end
			end
			if (!matched) begin
				expected = (FIELD_START >> (8 * k_now)) | {56'h0, model_player};
				$display("ERROR frame at field step %0d: expected %h, got %h",
					k_now, expected, frame);
				errors++;
			end else if ((base[7:0] & shown) != 8'h00) begin
				over_seen = 1'b1;
				frozen_frame = frame;
				if (game_over !== 1'b1) begin
					$display("ERROR game_over: expected 1, got %h", game_over);
					errors++;
				end
			end
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == test_errors) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests_run, name,
				errors - test_errors);
		end
		test_errors = errors;
	endtask

	initial begin : frame_watch
		forever begin
			@(frame_count);
			#1;
			check_frame();
		end
	end

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge clock_50);
		$display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

	// ##############################
	// Test sequence
	// ##############################
	initial begin : stimulus
		int waited;
		void'($urandom(37));
		rst_n = 1'b0;
		start_n = 1'b1;
		left_n = 1'b1;
		right_n = 1'b1;
		model_restore = 1'b1;
		step_left = 1'b0;
		step_right = 1'b0;
		mode = MODE_SKIP;
		k_now = 0;
		move_pending = 1'b0;
		over_seen = 1'b0;
		frozen_frame = '0;
		repeat (4) @(posedge clock_50);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		model_restore = 1'b0;

		if (max7219_ncs !== 1'b1) begin
			$display("ERROR max7219_ncs: expected 1, got %h", max7219_ncs);
			errors++;
		end
		if (max7219_clk !== 1'b0) begin
			$display("ERROR max7219_clk: expected 0, got %h", max7219_clk);
			errors++;
		end
		if (game_over !== 1'b0) begin
			$display("ERROR game_over: expected 0, got %h", game_over);
			errors++;
		end
		mode = MODE_IDLE;
		wait (word_count >= 5);
		for (int i = 0; i < 5; i++) begin
			if (first_words[16*i +: 16] !== CONFIG_EXPECTED[16*i +: 16]) begin
				$display("ERROR config word %0d: expected %h, got %h", i,
					CONFIG_EXPECTED[16*i +: 16], first_words[16*i +: 16]);
				errors++;
			end
		end
		finish_test("reset and config");

		wait_frames(3);
		finish_test("idle frame");

		mode = MODE_PLAY;
		press_pin(PIN_START);
		// Nothing can reach the player before the field has fallen two rows
		if (game_over !== 1'b0) begin
			$display("ERROR game_over: expected 0, got %h", game_over);
			errors++;
		end
		for (int i = 0; i < NUM_MOVES && k_now < 2; i++) begin
			move_player($urandom_range(0, 1) == 1);
		end
		// Column 1 dodges every obstacle row
		if (model_player == 8'h02)
			move_player(1'b1);
		if (k_now >= 2) begin
			$display("player moves were still running when the field reached step 2");
			errors++;
		end
		finish_test("player movement");

		waited = 0;
		while (!over_seen && waited < MAX_PLAY_FRAMES) begin
			wait_frames(1);
			waited++;
		end
		if (k_now < 2) begin
			$display("the field never scrolled past step 1");
			errors++;
		end
		finish_test("scrolling");

		if (!over_seen) begin
			$display("no collision was shown within %0d frames", MAX_PLAY_FRAMES);
			errors++;
		end
		wait_frames(3);
		if (game_over !== 1'b1) begin
			$display("ERROR game_over: expected 1, got %h", game_over);
			errors++;
		end
		mode = MODE_SKIP;
		@(posedge clock_50);
		#DRIVE_DELAY;
		model_restore = 1'b1;
		@(posedge clock_50);
		#DRIVE_DELAY;
		model_restore = 1'b0;
		press_pin(PIN_START);
		wait_frames(2);
		mode = MODE_IDLE;
		wait_frames(2);
		if (game_over !== 1'b0) begin
			$display("ERROR game_over: expected 0, got %h", game_over);
			errors++;
		end
		finish_test("collision and restart");

		$display("%0d tests, %0d failed, %0d errors, %0d frames checked",
			tests_run, tests_failed, errors, frames_checked);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
